/* rtl/soc_pkg.sv */
package soc_pkg;

  localparam int offset_w = 26;  // word offset width

  typedef enum logic [3:0] {
    region_rom   = 4'd0,
    region_ram   = 4'd1,
    region_timer = 4'd2,
    region_uart  = 4'd3
  } region_e;

  // one bus address, seen as a raw word or split into fields
  typedef union packed {
    logic [31:0] raw;
    struct packed {
      logic [3:0]          region;    // target select
      logic [offset_w-1:0] offset;    // word offset in target
      logic [1:0]          byte_idx;  // byte within word
    } fields;
  } bus_addr_u;

  // machine timer registers
  localparam logic [offset_w-1:0] timer_mtime_lo = 26'd0;
  localparam logic [offset_w-1:0] timer_mtime_hi = 26'd1;
  localparam logic [offset_w-1:0] timer_cmp_lo   = 26'd2;
  localparam logic [offset_w-1:0] timer_cmp_hi   = 26'd3;

  // serial transmitter registers
  localparam logic [offset_w-1:0] uart_data   = 26'd0;
  localparam logic [offset_w-1:0] uart_status = 26'd1;  // bit 0 busy

endpackage

/* rtl/bus_decoder.sv */
module bus_decoder (
  input  logic                         clock,
  input  logic                         reset,
  input  logic                         cyc,
  input  logic                         stb,
  input  logic                         we,
  input  soc_pkg::bus_addr_u           adr,
  input  logic [31:0]                  dat_w,
  input  logic [3:0]                   sel,
  output logic                         ack,
  output logic                         err,
  output logic [31:0]                  dat_r,
  output logic                         rom_stb,
  output logic                         ram_stb,
  output logic                         timer_stb,
  output logic                         uart_stb,
  output logic                         t_we,
  output logic [soc_pkg::offset_w-1:0] t_offset,
  output logic [31:0]                  t_dat_w,
  output logic [3:0]                   t_sel,
  input  logic                         rom_ack,
  input  logic [31:0]                  rom_dat,
  input  logic                         ram_ack,
  input  logic [31:0]                  ram_dat,
  input  logic                         timer_ack,
  input  logic [31:0]                  timer_dat,
  input  logic                         uart_ack,
  input  logic [31:0]                  uart_dat
);

  import soc_pkg::*;

  localparam logic [1:0] st_idle = 2'd0;
  localparam logic [1:0] st_busy = 2'd1;
  localparam logic [1:0] st_done = 2'd2;  // wait for stb to drop

  logic [1:0] state_q;
  region_e    target_q;
  logic       strobe_q;
  logic       err_pend_q;
  logic       err_q;
  logic       mapped;

  assign mapped = adr.fields.region inside {region_rom, region_ram, region_timer, region_uart};

  assign rom_stb   = strobe_q && (target_q == region_rom);
  assign ram_stb   = strobe_q && (target_q == region_ram);
  assign timer_stb = strobe_q && (target_q == region_timer);
  assign uart_stb  = strobe_q && (target_q == region_uart);

  // request fields are held by the master for the whole cycle
  assign t_we     = we;
  assign t_offset = adr.fields.offset;
  assign t_dat_w  = dat_w;
  assign t_sel    = sel;

  assign err = err_q;

  always_comb begin
    case (target_q)
      region_rom: begin
        ack   = rom_ack;
        dat_r = rom_dat;
      end
      region_ram: begin
        ack   = ram_ack;
        dat_r = ram_dat;
      end
      region_timer: begin
        ack   = timer_ack;
        dat_r = timer_dat;
      end
      default: begin
        ack   = uart_ack;
        dat_r = uart_dat;
      end
    endcase
    if (err_q) begin
      dat_r = '0;  // no data with an error
    end
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      state_q    <= st_idle;
      target_q   <= region_rom;
      strobe_q   <= 1'b0;
      err_pend_q <= 1'b0;
      err_q      <= 1'b0;
    end else begin
      err_q <= 1'b0;
      case (state_q)
        st_idle: begin
          if (cyc && stb) begin
            state_q <= st_busy;
            if (mapped) begin
              target_q <= region_e'(adr.fields.region);
              strobe_q <= 1'b1;
            end else begin
              err_pend_q <= 1'b1;  // answer ourselves next edge
            end
          end
        end
        st_busy: begin
          if (err_pend_q) begin
            err_q      <= 1'b1;
            err_pend_q <= 1'b0;
            state_q    <= st_done;
          end else if (ack) begin
            strobe_q <= 1'b0;
            state_q  <= st_done;
          end
        end
        st_done: begin
          if (!(cyc && stb)) begin
            state_q <= st_idle;
          end
        end
        default: state_q <= st_idle;
      endcase
    end
  end

endmodule

/* rtl/boot_rom.sv */
module boot_rom #(
  parameter int ROM_WORDS = 16
) (
  input  logic                         clock,
  input  logic                         reset,
  input  logic                         stb,
  input  logic [soc_pkg::offset_w-1:0] offset,
  output logic                         ack,
  output logic [31:0]                  dat
);

  logic [31:0] mem [ROM_WORDS];
  logic        access;

  initial begin
    $readmemh("rtl/boot_rom.hex", mem);
  end

  assign access = stb && !ack;  // one ack per strobe

  always_ff @(posedge clock) begin
    if (!reset) begin
      ack <= 1'b0;
    end else begin
      ack <= access;  // writes land here too and are dropped
    end
  end

  always_ff @(posedge clock) begin
    if (access) begin
      dat <= mem[offset % ROM_WORDS];  // wraps over rom size
    end
  end

endmodule

/* rtl/scratch_ram.sv */
module scratch_ram #(
  parameter int RAM_WORDS = 64
) (
  input  logic                         clock,
  input  logic                         reset,
  input  logic                         stb,
  input  logic                         we,
  input  logic [soc_pkg::offset_w-1:0] offset,
  input  logic [31:0]                  dat_w,
  input  logic [3:0]                   sel,
  output logic                         ack,
  output logic [31:0]                  dat
);

  logic [31:0] mem [RAM_WORDS];
  logic        access;
  logic [31:0] index;

  assign access = stb && !ack;
  assign index  = offset % RAM_WORDS;

  always_ff @(posedge clock) begin
    if (!reset) begin
      ack <= 1'b0;
    end else begin
      ack <= access;
    end
  end

  // storage and read port
  always_ff @(posedge clock) begin
    if (access) begin
      dat <= mem[index];
      if (we) begin
        for (int i = 0; i < 4; i++) begin
          if (sel[i]) begin
            mem[index][8*i +: 8] <= dat_w[8*i +: 8];  // only enabled lanes
          end
        end
      end
    end
  end

endmodule

/* rtl/machine_timer.sv */
module machine_timer #(
  parameter int TICK_DIV = 4
) (
  input  logic                         clock,
  input  logic                         reset,
  input  logic                         stb,
  input  logic                         we,
  input  logic [soc_pkg::offset_w-1:0] offset,
  input  logic [31:0]                  dat_w,
  output logic                         ack,
  output logic [31:0]                  dat,
  output logic                         mtip
);

  import soc_pkg::*;

  localparam int div_w = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;

  logic [div_w-1:0] div_q;
  logic             tick;
  logic [63:0]      mtime_q;
  logic [63:0]      cmp_q;
  logic             access;

  assign tick   = (div_q == div_w'(TICK_DIV - 1));
  assign access = stb && !ack;
  assign mtip   = (mtime_q >= cmp_q);

  always_ff @(posedge clock) begin
    if (!reset) begin
      div_q   <= '0;
      mtime_q <= '0;
      cmp_q   <= '1;  // keeps mtip low
      ack     <= 1'b0;
    end else begin
      ack <= access;
      if (tick) begin
        div_q   <= '0;
        mtime_q <= mtime_q + 64'd1;
      end else begin
        div_q <= div_q + 1'b1;
      end
      if (access && we) begin
        case (offset)
          timer_cmp_lo: cmp_q[31:0]  <= dat_w;
          timer_cmp_hi: cmp_q[63:32] <= dat_w;
          default: ;  // mtime is read only
        endcase
      end
    end
  end

  always_ff @(posedge clock) begin
    if (access) begin
      case (offset)
        timer_mtime_lo: dat <= mtime_q[31:0];
        timer_mtime_hi: dat <= mtime_q[63:32];
        timer_cmp_lo:   dat <= cmp_q[31:0];
        timer_cmp_hi:   dat <= cmp_q[63:32];
        default:        dat <= '0;
      endcase
    end
  end

endmodule

/* rtl/uart_tx.sv */
module uart_tx #(
  parameter int BAUD_DIV = 8
) (
  input  logic                         clock,
  input  logic                         reset,
  input  logic                         stb,
  input  logic                         we,
  input  logic [soc_pkg::offset_w-1:0] offset,
  input  logic [31:0]                  dat_w,
  output logic                         ack,
  output logic [31:0]                  dat,
  output logic                         tx
);

  import soc_pkg::*;

  localparam int baud_w = (BAUD_DIV > 1) ? $clog2(BAUD_DIV) : 1;

  logic [9:0]        shift_q;  // stop, data, start
  logic [baud_w-1:0] baud_q;
  logic [3:0]        bit_q;
  logic              busy_q;
  logic              data_wr;
  logic              accept;
  logic              bit_end;

  assign data_wr = we && (offset == uart_data);
  assign bit_end = (baud_q == baud_w'(BAUD_DIV - 1));
  assign tx      = shift_q[0];

  // a data write waits here until the running frame is out
  assign accept = stb && !ack && !(data_wr && busy_q);

  always_ff @(posedge clock) begin
    if (!reset) begin
      ack     <= 1'b0;
      shift_q <= '1;  // line idles high
      baud_q  <= '0;
      bit_q   <= '0;
      busy_q  <= 1'b0;
    end else begin
      ack <= accept;
      if (accept && data_wr) begin
        shift_q <= {1'b1, dat_w[7:0], 1'b0};
        baud_q  <= '0;
        bit_q   <= '0;
        busy_q  <= 1'b1;
      end else if (busy_q) begin
        if (bit_end) begin
          baud_q  <= '0;
          shift_q <= {1'b1, shift_q[9:1]};  // lsb first
          if (bit_q == 4'd9) begin
            busy_q <= 1'b0;  // stop bit done
          end else begin
            bit_q <= bit_q + 4'd1;
          end
        end else begin
          baud_q <= baud_q + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clock) begin
    if (accept) begin
      if (offset == uart_status) begin
        dat <= {31'b0, busy_q};
      end else begin
        dat <= '0;  // data reads back as zero
      end
    end
  end

endmodule

/* rtl/peripheral_soc.sv */
module peripheral_soc #(
  parameter int ROM_WORDS = 16,
  parameter int RAM_WORDS = 64,
  parameter int TICK_DIV  = 4,
  parameter int BAUD_DIV  = 8
) (
  input  logic        clock,
  input  logic        reset,
  input  logic        cyc,
  input  logic        stb,
  input  logic        we,
  input  logic [31:0] adr,
  input  logic [31:0] dat_w,
  input  logic [3:0]  sel,
  output logic        ack,
  output logic        err,
  output logic [31:0] dat_r,
  output logic        mtip,
  output logic        tx
);

  import soc_pkg::*;

  logic                rom_stb;
  logic                ram_stb;
  logic                timer_stb;
  logic                uart_stb;
  logic                t_we;
  logic [offset_w-1:0] t_offset;
  logic [31:0]         t_dat_w;
  logic [3:0]          t_sel;
  logic                rom_ack;
  logic                ram_ack;
  logic                timer_ack;
  logic                uart_ack;
  logic [31:0]         rom_dat;
  logic [31:0]         ram_dat;
  logic [31:0]         timer_dat;
  logic [31:0]         uart_dat;

  bus_decoder u_bus_decoder (
    .clock     (clock),
    .reset     (reset),
    .cyc       (cyc),
    .stb       (stb),
    .we        (we),
    .adr       (adr),
    .dat_w     (dat_w),
    .sel       (sel),
    .ack       (ack),
    .err       (err),
    .dat_r     (dat_r),
    .rom_stb   (rom_stb),
    .ram_stb   (ram_stb),
    .timer_stb (timer_stb),
    .uart_stb  (uart_stb),
    .t_we      (t_we),
    .t_offset  (t_offset),
    .t_dat_w   (t_dat_w),
    .t_sel     (t_sel),
    .rom_ack   (rom_ack),
    .rom_dat   (rom_dat),
    .ram_ack   (ram_ack),
    .ram_dat   (ram_dat),
    .timer_ack (timer_ack),
    .timer_dat (timer_dat),
    .uart_ack  (uart_ack),
    .uart_dat  (uart_dat)
  );

  boot_rom #(.ROM_WORDS(ROM_WORDS)) u_boot_rom (
    .clock  (clock),
    .reset  (reset),
    .stb    (rom_stb),
    .offset (t_offset),
    .ack    (rom_ack),
    .dat    (rom_dat)
  );

  scratch_ram #(.RAM_WORDS(RAM_WORDS)) u_scratch_ram (
    .clock  (clock),
    .reset  (reset),
    .stb    (ram_stb),
    .we     (t_we),
    .offset (t_offset),
    .dat_w  (t_dat_w),
    .sel    (t_sel),
    .ack    (ram_ack),
    .dat    (ram_dat)
  );

  machine_timer #(.TICK_DIV(TICK_DIV)) u_machine_timer (
    .clock  (clock),
    .reset  (reset),
    .stb    (timer_stb),
    .we     (t_we),
    .offset (t_offset),
    .dat_w  (t_dat_w),
    .ack    (timer_ack),
    .dat    (timer_dat),
    .mtip   (mtip)
  );

  uart_tx #(.BAUD_DIV(BAUD_DIV)) u_uart_tx (
    .clock  (clock),
    .reset  (reset),
    .stb    (uart_stb),
    .we     (t_we),
    .offset (t_offset),
    .dat_w  (t_dat_w),
    .ack    (uart_ack),
    .dat    (uart_dat),
    .tx     (tx)
  );

endmodule

/* test/soc_tb.sv */
module soc_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int baud_div = 8;
  localparam int tick_div = 4;
  localparam int bit_ns   = baud_div * 20;
  localparam int frame_ns = 10 * bit_ns;

  typedef struct packed {
    logic        w;
    logic [31:0] a;
    logic [31:0] d;
    logic [3:0]  s;
    logic        exp_err;
    logic [31:0] exp_dat;
    logic        cmp;
  } row_t;

  logic        clock;
  logic        reset;
  logic        cyc;
  logic        stb;
  logic        we;
  logic [31:0] adr;
  logic [31:0] dat_w;
  logic [3:0]  sel;
  logic        ack;
  logic        err;
  logic [31:0] dat_r;
  logic        mtip;
  logic        tx;

  row_t        rows[$];
  logic [31:0] rom_img [16];
  logic [31:0] ram_model [64];
  logic [7:0]  rx_q[$];
  logic        table_built;
  integer      seed;

  peripheral_soc #(.TICK_DIV(tick_div), .BAUD_DIV(baud_div)) u_peripheral_soc (
    .clock (clock),
    .reset (reset),
    .cyc   (cyc),
    .stb   (stb),
    .we    (we),
    .adr   (adr),
    .dat_w (dat_w),
    .sel   (sel),
    .ack   (ack),
    .err   (err),
    .dat_r (dat_r),
    .mtip  (mtip),
    .tx    (tx)
  );

  always #10 clock = ~clock;

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
      $display("sim failed");
      $fatal(1);
    end
  endtask

  function automatic logic [31:0] merge_lanes(input logic [31:0] old_w,
                                              input logic [31:0] new_w,
                                              input logic [3:0]  s);
    logic [31:0] r;
    r = old_w;
    for (int i = 0; i < 4; i++) begin
      if (s[i]) begin
        r[8*i +: 8] = new_w[8*i +: 8];
      end
    end
    return r;
  endfunction

  task automatic add_row(input logic w, input logic [31:0] a, input logic [31:0] d,
                         input logic [3:0] s, input logic e, input logic [31:0] x,
                         input logic c);
    rows.push_back(row_t'{w, a, d, s, e, x, c});
  endtask

  task automatic ram_write(input int idx, input logic [31:0] d, input logic [3:0] s);
    ram_model[idx] = merge_lanes(ram_model[idx], d, s);
    add_row(1'b1, 32'h1000_0000 + idx * 4, d, s, 1'b0, '0, 1'b0);
  endtask

  task automatic ram_read(input int idx);
    add_row(1'b0, 32'h1000_0000 + idx * 4, '0, 4'hf, 1'b0, ram_model[idx], 1'b1);
  endtask

  // one wishbone classic transfer sampled at the falling edge
  task automatic bus_xfer(input logic w, input logic [31:0] a, input logic [31:0] d,
                          input logic [3:0] s, output logic [31:0] rd,
                          output logic got_err, output time t_end);
    @(posedge clock);
    #1;
    cyc   = 1'b1;
    stb   = 1'b1;
    we    = w;
    adr   = a;
    dat_w = d;
    sel   = s;
    do begin
      @(negedge clock);
    end while (!(ack || err));
    check_value("ack", ack, !err);  // never both
    rd      = dat_r;
    got_err = err;
    t_end   = $time;
    @(posedge clock);
    #1;
    cyc = 1'b0;
    stb = 1'b0;
  endtask

  initial begin : rx_monitor
    logic [7:0] rx_byte;
    forever begin
      @(negedge tx);
      #(bit_ns / 2 + 5);  // middle of the bit clear of clock edges
      check_value("tx start bit", tx, 1'b0);
      for (int i = 0; i < 8; i++) begin
        #(bit_ns);
        rx_byte[i] = tx;
      end
      #(bit_ns);
      check_value("tx stop bit", tx, 1'b1);
      rx_q.push_back(rx_byte);
    end
  end

  initial begin : watchdog
    wait (table_built);
    repeat (rows.size() * 20 + 12 * 10 * baud_div) @(posedge clock);
    $display("run timed out before all transfers finished");
    $display("sim failed");
    $fatal(1);
  end

  initial begin : main
    logic [31:0] rd;
    logic [31:0] prev;
    logic [31:0] r;
    logic        e;
    time         t1;
    time         t2;
    logic [7:0]  b [3];
    int          polls;
    clock       = 1'b0;
    reset       = 1'b0;
    cyc         = 1'b0;
    stb         = 1'b0;
    we          = 1'b0;
    adr         = '0;
    dat_w       = '0;
    sel         = '0;
    table_built = 1'b0;
    seed        = 51017;
    $readmemh("rtl/boot_rom.hex", rom_img);

    for (int i = 0; i < 16; i++) begin
      add_row(1'b0, i * 4, '0, 4'hf, 1'b0, rom_img[i], 1'b1);
    end
    add_row(1'b0, 32'h0000_0040, '0, 4'hf, 1'b0, rom_img[0], 1'b1);  // wraps
    add_row(1'b1, 32'h0000_0008, 32'hdead_beef, 4'hf, 1'b0, '0, 1'b0);
    add_row(1'b0, 32'h0000_0008, '0, 4'hf, 1'b0, rom_img[2], 1'b1);
    for (int i = 0; i < 4; i++) begin
      r = $random(seed);
      ram_write(i, r, 4'hf);
    end
    r = $random(seed);
    ram_write(0, r, 4'b0001);
    r = $random(seed);
    ram_write(1, r, 4'b0110);
    r = $random(seed);
    ram_write(2, r, 4'b1000);
    add_row(1'b0, 32'h4000_0000, '0, 4'hf, 1'b1, '0, 1'b0);
    ram_read(0);
    add_row(1'b1, 32'h9000_0010, 32'h1234_5678, 4'hf, 1'b1, '0, 1'b0);
    ram_read(1);
    add_row(1'b0, 32'hf000_0000, '0, 4'hf, 1'b1, '0, 1'b0);
    ram_read(2);
    ram_read(3);
    table_built = 1'b1;

    repeat (2) @(posedge clock);
    #1;
    reset = 1'b1;
    check_value("mtip", mtip, 1'b0);

    foreach (rows[i]) begin
      bus_xfer(rows[i].w, rows[i].a, rows[i].d, rows[i].s, rd, e, t1);
      check_value("err", e, rows[i].exp_err);
      if (rows[i].cmp) begin
        check_value("dat_r", rd, rows[i].exp_dat);
      end
    end

    // high timer half first so mtip stays low meanwhile
    bus_xfer(1'b1, 32'h2000_000c, 32'h0, 4'hf, rd, e, t1);
    bus_xfer(1'b1, 32'h2000_0008, 32'd40, 4'hf, rd, e, t1);
    prev  = '0;
    polls = 0;
    do begin
      bus_xfer(1'b0, 32'h2000_0000, '0, 4'hf, rd, e, t1);
      check_value("mtime_lo not decreasing", rd >= prev, 1'b1);
      prev  = rd;
      polls = polls + 1;
      if (polls > 200) begin
        $display("mtime never reached the compare value");
        $display("sim failed");
        $fatal(1);
      end
    end while (rd < 32'd40);
    check_value("mtip", mtip, 1'b1);
    bus_xfer(1'b1, 32'h2000_0008, 32'hffff_ffff, 4'hf, rd, e, t1);
    bus_xfer(1'b1, 32'h2000_000c, 32'hffff_ffff, 4'hf, rd, e, t1);
    check_value("mtip", mtip, 1'b0);

    // single frame then two writes back to back
    for (int i = 0; i < 3; i++) begin
      r    = $random(seed);
      b[i] = r[7:0];
    end
    bus_xfer(1'b1, 32'h3000_0000, {24'h0, b[0]}, 4'hf, rd, e, t1);
    bus_xfer(1'b0, 32'h3000_0004, '0, 4'hf, rd, e, t1);
    check_value("uart busy", rd[0], 1'b1);
    wait (rx_q.size() == 1);
    repeat (baud_div) @(posedge clock);  // rest of the stop bit
    bus_xfer(1'b0, 32'h3000_0004, '0, 4'hf, rd, e, t1);
    check_value("uart busy", rd[0], 1'b0);
    check_value("rx byte 0", rx_q[0], b[0]);
    bus_xfer(1'b1, 32'h3000_0000, {24'h0, b[1]}, 4'hf, rd, e, t1);
    bus_xfer(1'b1, 32'h3000_0000, {24'h0, b[2]}, 4'hf, rd, e, t2);
    check_value("second ack after first frame", (t2 - t1) >= frame_ns, 1'b1);
    wait (rx_q.size() == 3);
    check_value("rx byte 1", rx_q[1], b[1]);
    check_value("rx byte 2", rx_q[2], b[2]);

    $display("sim passed");
    $finish;
  end

endmodule

/* rtl/boot_rom.hex */
// one 32-bit rom word per line, word 0 first
00000297
02028293
30529073
00001137
ff010113
10000517
00050513
00052583
00b52223
20000617
00062683
00168693
00d62423
0000006f
c0de5a01
c0de5a0f

/* sources.f */
rtl/soc_pkg.sv
rtl/bus_decoder.sv
rtl/boot_rom.sv
rtl/scratch_ram.sv
rtl/machine_timer.sv
rtl/uart_tx.sv
rtl/peripheral_soc.sv
test/soc_tb.sv

/* Bender.yml */
package:
  name: peripheral_soc

sources:
  - rtl/soc_pkg.sv
  - rtl/bus_decoder.sv
  - rtl/boot_rom.sv
  - rtl/scratch_ram.sv
  - rtl/machine_timer.sv
  - rtl/uart_tx.sv
  - rtl/peripheral_soc.sv
  - target: test
    files:
      - test/soc_tb.sv
